/* list.f */
+incdir+hdl
hdl/mpu_pkg.sv
hdl/mpu_csr.sv
hdl/mpu_match.sv
hdl/mpu_resp.sv
hdl/mpu_top.sv
bench/mpu_checker.sv
bench/mpu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= mpu_tb
SEED_FLAGS ?= --x-assign 0 --x-initial 0
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
FILELIST   ?= list.f
PASS_TEXT  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) $(SEED_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/mpu_tb.sv */
`timescale 1ns/1ps
`include "mpu_defines.svh"

module mpu_tb;

    import mpu_pkg::*;

    localparam int RST_CYC  = 5;
    localparam int N_ATTR   = 30;
    localparam int N_WRITES = 400;
    localparam int N_LOCKS  = 100;
    localparam int N_ACC    = 600;
    // checked writes take two cycles, accesses up to two with a gap.
    localparam int TIMEOUT_CYCLES = RST_CYC + 40 + (N_ATTR + 1) + 2 * N_WRITES
                                  + 2 * (8 + 32 + N_LOCKS) + (2 * N_ACC + 1) + 100;
    localparam logic [63:0] ADDR_KEEP = (64'd1 << (`PADDR_LEN - 2)) - 64'd1;

    logic               clk;
    logic               rstn;
    logic               csr_wr;
    logic [11:0]        csr_waddr;
    logic [`XLEN-1:0]   csr_wdata;
    logic [11:0]        csr_raddr;
    logic [`XLEN-1:0]   csr_rdata;
    logic               req_valid;
    mpu_req_t           req;
    logic               resp_valid;
    mpu_resp_t          resp;

    integer             seed;
    int                 cycles;
    logic [31:0]        rnd;
    logic               exp_valid;
    mpu_resp_t          exp_resp;
    // table 0 is pmp, table 1 is pma.
    mpu_cfg_u           m_cfg  [2][`MPU_ENTRIES];
    logic [`XLEN-1:0]   m_addr [2][`MPU_ENTRIES];

    mpu_top dut (
        .clk        (clk),
        .rstn       (rstn),
        .csr_wr     (csr_wr),
        .csr_waddr  (csr_waddr),
        .csr_wdata  (csr_wdata),
        .csr_raddr  (csr_raddr),
        .csr_rdata  (csr_rdata),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test did not finish within %0d cycles", cycles);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    // kind 1 is a config register, kind 2 an address register.
    function automatic void decode(input logic [11:0] a, output int kind,
                                   output int t, output int idx);
        logic [11:0] cfg_base [2];
        logic [11:0] addr_base [2];
        cfg_base = '{`CSR_PMPCFG0, `CSR_PMACFG0};
        addr_base = '{`CSR_PMPADDR0, `CSR_PMAADDR0};
        kind = 0;
        t = 0;
        idx = 0;
        for (int b = 0; b < 2; b++) begin
            if (a - cfg_base[b] < 12'd4) begin
                kind = 1;
                t = b;
                idx = 4 * int'(a - cfg_base[b]);
            end
            if (a - addr_base[b] < 12'd16) begin
                kind = 2;
                t = b;
                idx = int'(a - addr_base[b]);
            end
        end
    endfunction

    function automatic logic [`XLEN-1:0] model_read(input logic [11:0] a);
        int kind;
        int t;
        int idx;
        logic [`XLEN-1:0] v;
        decode(a, kind, t, idx);
        v = '0;
        if (kind == 1) begin
            for (int j = 0; j < 4; j++) begin
                v[8*j +: 8] = m_cfg[t][idx+j];
            end
        end else if (kind == 2) begin
            v = m_addr[t][idx];
            // off and tor entries read with the low run of ones cleared.
            if (!m_cfg[t][idx].pmp.a[1]) begin
                for (int k = 0; k < `XLEN && v[k]; k++) begin
                    v[k] = 1'b0;
                end
            end
        end
        return v;
    endfunction

    function automatic void model_write(input logic [11:0] a, input logic [`XLEN-1:0] d);
        int kind;
        int t;
        int idx;
        mpu_cfg_u b;
        mpu_cfg_u nxt;
        decode(a, kind, t, idx);
        if (kind == 1) begin
            for (int j = 0; j < 4; j++) begin
                b = d[8*j +: 8];
                if (t == 0) begin
                    b.pmp.rsvd = 2'b00;
                    if (!b.pmp.r) begin
                        b.pmp.w = 1'b0;
                    end
                end else begin
                    b.pma.rsvd0 = 2'b00;
                    b.pma.rsvd1 = 1'b0;
                end
                if (!m_cfg[t][idx+j].pmp.l) begin
                    m_cfg[t][idx+j] = b;
                end
            end
        end else if (kind == 2) begin
            nxt = '0;
            if (idx < `MPU_ENTRIES - 1) begin
                nxt = m_cfg[t][idx+1];
            end
            if (!m_cfg[t][idx].pmp.l && !(nxt.pmp.l && nxt.pmp.a == `A_TOR)) begin
                m_addr[t][idx] = d & ADDR_KEEP[`XLEN-1:0];
            end
        end
    endfunction

    function automatic mpu_hit_t model_match(input int t, input logic [`PADDR_LEN-1:0] paddr);
        mpu_hit_t r;
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] lo;
        logic [`XLEN-1:0] top;
        int n;
        logic hit;
        r = '0;
        word = paddr[`PADDR_LEN-1:2];
        lo = '0;
        for (int i = 0; i < `MPU_ENTRIES; i++) begin
            top = m_addr[t][i];
            n = 0;
            while (n < `XLEN && top[n]) begin
                n++;
            end
            case (m_cfg[t][i].pmp.a)
                `A_TOR:   hit = (word >= lo) && (word < top);
                `A_NA4:   hit = (word == top);
                `A_NAPOT: hit = (word >> (n + 1)) == (top >> (n + 1));
                default:  hit = 1'b0;
            endcase
            if (hit && !r.hit) begin
                r.hit = 1'b1;
                r.cfg = m_cfg[t][i];
            end
            lo = top;
        end
        return r;
    endfunction

    function automatic mpu_resp_t model_resp(input mpu_req_t r);
        mpu_resp_t o;
        mpu_hit_t ph;
        mpu_hit_t ah;
        logic allow;
        ph = model_match(0, r.paddr);
        ah = model_match(1, r.paddr);
        allow = (r.acc == acc_read)  ? ph.cfg.pmp.r :
                (r.acc == acc_write) ? ph.cfg.pmp.w : ph.cfg.pmp.x;
        if (!ph.hit) begin
            o.pmp_fault = !r.m_mode;
        end else if (r.m_mode && !ph.cfg.pmp.l) begin
            o.pmp_fault = 1'b0;
        end else begin
            o.pmp_fault = !allow;
        end
        o.pma_fault = !ah.hit || (r.acc == acc_exec && !ah.cfg.pma.e);
        o.cacheable = ah.hit && ah.cfg.pma.c && !o.pma_fault;
        return o;
    endfunction

    function automatic mpu_req_t rand_req();
        mpu_req_t r;
        logic [31:0] sel;
        logic [`XLEN-1:0] w;
        sel = $random(seed);
        w = $random(seed);
        // signed remainder puts half of the accesses within two words of an entry.
        if (sel[0]) begin
            w = m_addr[sel[1]][sel[5:2]] + 32'($random(seed) % 3);
        end
        r.paddr = {w, 2'b00};
        r.acc = access_t'(sel[9:8] % 2'd3);
        r.m_mode = sel[10];
        return r;
    endfunction

    task automatic check_rdata(input logic [11:0] a, input logic [`XLEN-1:0] exp,
                               input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH csr_rdata at %h: expected %h, actual %h", a, exp, act);
            $display("Simulation failed");
            $fatal(1, "csr readback error");
        end
    endtask

    task automatic check_resp(input mpu_resp_t exp, input mpu_resp_t act);
        if (act !== exp) begin
            $display("MISMATCH resp: expected %h, actual %h", exp, act);
            $display("Simulation failed");
            $fatal(1, "verdict error");
        end
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH resp_valid: expected %h, actual %h", exp, act);
            $display("Simulation failed");
            $fatal(1, "valid error");
        end
    endtask

    task automatic read_check(input logic [11:0] a);
        @(negedge clk);
        csr_wr = 1'b0;
        csr_raddr = a;
        #10;
        check_rdata(a, model_read(a), csr_rdata);
    endtask

    task automatic write_check(input logic [11:0] a, input logic [`XLEN-1:0] d);
        @(negedge clk);
        csr_wr = 1'b1;
        csr_waddr = a;
        csr_wdata = d;
        model_write(a, d);
        read_check(a);
    endtask

    // checks the verdict of the previous cycle, then drives the next request.
    task automatic access_cycle(input logic v, input mpu_req_t r);
        @(negedge clk);
        check_valid(exp_valid, resp_valid);
        check_resp(exp_resp, resp);
        req_valid = v;
        req = r;
        exp_valid = v;
        if (v) begin
            exp_resp = model_resp(r);
        end
    endtask

    initial begin
        logic [11:0] a;
        logic [`XLEN-1:0] d;
        mpu_req_t r;
        seed = 32'h45bf3e27;
        rstn = 1'b0;
        csr_wr = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        csr_raddr = '0;
        req_valid = 1'b0;
        req = '0;
        r = '0;
        exp_valid = 1'b0;
        exp_resp = '0;
        for (int i = 0; i < `MPU_ENTRIES; i++) begin
            m_cfg[0][i] = '0;
            m_cfg[1][i] = '0;
            m_addr[0][i] = '0;
            m_addr[1][i] = '0;
        end
        m_cfg[1][0] = `PMA0_RST_CFG;
        m_addr[1][0] = `PMA0_RST_ADDR;
        m_cfg[1][1] = `PMA1_RST_CFG;
        m_addr[1][1] = `PMA1_RST_ADDR;
        repeat (RST_CYC) @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < `MPU_ENTRIES; i++) begin
            read_check(`CSR_PMPADDR0 + 12'(i));
            read_check(`CSR_PMAADDR0 + 12'(i));
            if (i < 4) begin
                read_check(`CSR_PMPCFG0 + 12'(i));
                read_check(`CSR_PMACFG0 + 12'(i));
            end
            check_valid(1'b0, resp_valid);
        end

        // loads and fetches in the two reset regions and above them.
        for (int i = 0; i < N_ATTR; i++) begin
            rnd = $random(seed);
            case (i % 3)
                0:       d = rnd % 32'h0100_0000;
                1:       d = 32'h0100_0000 + rnd % 32'h0F00_0000;
                default: d = 32'h1000_0000 + rnd % 32'hF000_0000;
            endcase
            r.paddr = {d, 2'b00};
            r.acc = rnd[31] ? acc_exec : acc_read;
            r.m_mode = rnd[30];
            access_cycle(1'b1, r);
        end
        access_cycle(1'b0, r);

        for (int i = 0; i < N_WRITES; i++) begin
            rnd = $random(seed);
            d = $random(seed);
            case (rnd[1:0])
                2'd0:    a = `CSR_PMPCFG0 + 12'(rnd[3:2]);
                2'd1:    a = `CSR_PMACFG0 + 12'(rnd[3:2]);
                2'd2:    a = `CSR_PMPADDR0 + 12'(rnd[7:4]);
                default: a = `CSR_PMAADDR0 + 12'(rnd[7:4]);
            endcase
            // lock bits stay clear until the locking phase.
            if (!rnd[1]) begin
                d = d & 32'h7f7f_7f7f;
            end
            write_check(a, d);
        end

        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            write_check(`CSR_PMPCFG0 + 12'(i), ($random(seed) & 32'h7f7f_7f7f) |
                                               (rnd & 32'h8080_8080));
            rnd = $random(seed);
            write_check(`CSR_PMACFG0 + 12'(i), ($random(seed) & 32'h7f7f_7f7f) |
                                               (rnd & 32'h8080_8080));
        end
        for (int i = 0; i < `MPU_ENTRIES; i++) begin
            write_check(`CSR_PMPADDR0 + 12'(i), $random(seed));
            write_check(`CSR_PMAADDR0 + 12'(i), $random(seed));
        end
        for (int i = 0; i < N_LOCKS; i++) begin
            rnd = $random(seed);
            a = rnd[8] ? `CSR_PMPCFG0 + 12'(rnd[1:0]) : `CSR_PMPADDR0 + 12'(rnd[3:0]);
            a = a + (rnd[9] ? 12'h020 : 12'h000);
            write_check(a, $random(seed));
        end

        for (int i = 0; i < N_ACC; i++) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'd0) begin
                access_cycle(1'b0, r);
            end
            access_cycle(1'b1, rand_req());
        end
        access_cycle(1'b0, r);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* bench/mpu_checker.sv */
`timescale 1ns/1ps
`include "mpu_defines.svh"

module mpu_checker (
    input logic                clk,
    input logic                rstn,
    input logic                req_valid,
    input logic                resp_valid,
    input mpu_pkg::mpu_resp_t  resp,
    input logic [`XLEN-1:0]    csr_rdata
);

    a_reset_quiet: assert property (@(posedge clk) !rstn |-> !resp_valid)
        else $error("resp_valid high during reset");

    // one verdict per request, exactly one edge later.
    a_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid == $past(req_valid))
        else $error("resp_valid does not follow req_valid by one cycle");

    a_cache_ok: assert property (@(posedge clk) disable iff (!rstn)
        resp.cacheable |-> !resp.pma_fault)
        else $error("cacheable verdict together with a pma fault");

    a_rdata_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(csr_rdata))
        else $error("csr_rdata has unknown bits");

endmodule

bind mpu_top mpu_checker u_checker (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .resp_valid (resp_valid),
    .resp       (resp),
    .csr_rdata  (csr_rdata)
);

/* hdl/mpu_top.sv */
`timescale 1ns/1ps
`include "mpu_defines.svh"

module mpu_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                csr_wr,
    input  logic [11:0]         csr_waddr,
    input  logic [`XLEN-1:0]    csr_wdata,
    input  logic [11:0]         csr_raddr,
    output logic [`XLEN-1:0]    csr_rdata,
    input  logic                req_valid,
    input  mpu_pkg::mpu_req_t   req,
    output logic                resp_valid,
    output mpu_pkg::mpu_resp_t  resp
);

    import mpu_pkg::*;

    mpu_cfg_u         pmpcfg  [`MPU_ENTRIES];
    logic [`XLEN-1:0] pmpaddr [`MPU_ENTRIES];
    mpu_cfg_u         pmacfg  [`MPU_ENTRIES];
    logic [`XLEN-1:0] pmaaddr [`MPU_ENTRIES];
    mpu_hit_t         pmp_hit;
    mpu_hit_t         pma_hit;

    mpu_csr u_csr (
        .clk       (clk),
        .rstn      (rstn),
        .csr_wr    (csr_wr),
        .csr_waddr (csr_waddr),
        .csr_raddr (csr_raddr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .pmpcfg    (pmpcfg),
        .pmpaddr   (pmpaddr),
        .pmacfg    (pmacfg),
        .pmaaddr   (pmaaddr)
    );

    mpu_match pmp_match (
        .cfg    (pmpcfg),
        .addr   (pmpaddr),
        .paddr  (req.paddr),
        .result (pmp_hit)
    );

    mpu_match pma_match (
        .cfg    (pmacfg),
        .addr   (pmaaddr),
        .paddr  (req.paddr),
        .result (pma_hit)
    );

    mpu_resp u_resp (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .pmp_hit    (pmp_hit),
        .pma_hit    (pma_hit),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

/* hdl/mpu_resp.sv */
`timescale 1ns/1ps
`include "mpu_defines.svh"

module mpu_resp (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req_valid,
    input  mpu_pkg::mpu_req_t   req,
    input  mpu_pkg::mpu_hit_t   pmp_hit,
    input  mpu_pkg::mpu_hit_t   pma_hit,
    output logic                resp_valid,
    output mpu_pkg::mpu_resp_t  resp
);

    import mpu_pkg::*;

    logic      perm;
    mpu_resp_t resp_d;

    always_comb begin
        case (req.acc)
            acc_read:  perm = pmp_hit.cfg.pmp.r;
            acc_write: perm = pmp_hit.cfg.pmp.w;
            acc_exec:  perm = pmp_hit.cfg.pmp.x;
            default:   perm = 1'b0;
        endcase

        // machine mode is only held to locked entries.
        if (pmp_hit.hit) begin
            resp_d.pmp_fault = !perm && (!req.m_mode || pmp_hit.cfg.pmp.l);
        end else begin
            resp_d.pmp_fault = !req.m_mode;
        end

        resp_d.pma_fault = !pma_hit.hit || ((req.acc == acc_exec) && !pma_hit.cfg.pma.e);
        // a faulting access is never reported as cacheable.
        resp_d.cacheable = pma_hit.hit && pma_hit.cfg.pma.c && !resp_d.pma_fault;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            resp_valid <= req_valid;
            if (req_valid) begin
                resp <= resp_d;
            end
        end
    end

endmodule

/* hdl/mpu_match.sv */
`timescale 1ns/1ps
`include "mpu_defines.svh"

module mpu_match (
    input  mpu_pkg::mpu_cfg_u       cfg  [`MPU_ENTRIES],
    input  logic [`XLEN-1:0]        addr [`MPU_ENTRIES],
    input  logic [`PADDR_LEN-1:0]   paddr,
    output mpu_pkg::mpu_hit_t       result
);

    import mpu_pkg::*;

    localparam int N = `MPU_ENTRIES;
    localparam int W = `PADDR_LEN - 2;

    logic [W-1:0] waddr;
    logic [W-1:0] base [N];
    logic [W-1:0] lo   [N];
    logic [N-1:0] hit;

    assign waddr = paddr[`PADDR_LEN-1:2];

    // tor regions start at the previous entry's address.
    always_comb begin
        for (int i = 0; i < N; i++) begin
            base[i] = addr[i][W-1:0];
        end
        lo[0] = '0;
        for (int i = 1; i < N; i++) begin
            lo[i] = base[i-1];
        end
    end

    always_comb begin
        logic [W-1:0] napot_mask;
        for (int i = 0; i < N; i++) begin
            // trailing ones plus the next bit are don't-care.
            napot_mask = ~(base[i] ^ (base[i] + 1'b1));
            case (cfg[i].pmp.a)
                `A_TOR: begin
                    hit[i] = (waddr >= lo[i]) && (waddr < base[i]);
                end
                `A_NA4: begin
                    hit[i] = (waddr == base[i]);
                end
                `A_NAPOT: begin
                    hit[i] = ((waddr ^ base[i]) & napot_mask) == '0;
                end
                default: begin
                    hit[i] = 1'b0;
                end
            endcase
        end
    end

    // walk down so the lowest hitting entry is the last one written.
    always_comb begin
        result = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (hit[i]) begin
                result.hit = 1'b1;
                result.cfg = cfg[i];
            end
        end
    end

endmodule

/* hdl/mpu_csr.sv */
`timescale 1ns/1ps
`include "mpu_defines.svh"

module mpu_csr (
    input  logic                clk,
    input  logic                rstn,
    input  logic                csr_wr,
    input  logic [11:0]         csr_waddr,
    input  logic [11:0]         csr_raddr,
    input  logic [`XLEN-1:0]    csr_wdata,
    output logic [`XLEN-1:0]    csr_rdata,
    output mpu_pkg::mpu_cfg_u   pmpcfg  [`MPU_ENTRIES],
    output logic [`XLEN-1:0]    pmpaddr [`MPU_ENTRIES],
    output mpu_pkg::mpu_cfg_u   pmacfg  [`MPU_ENTRIES],
    output logic [`XLEN-1:0]    pmaaddr [`MPU_ENTRIES]
);

    import mpu_pkg::*;

    localparam int N = `MPU_ENTRIES;
    localparam logic [63:0] ADDR_MASK64 = (64'd1 << (`PADDR_LEN - 2)) - 64'd1;
    localparam logic [`XLEN-1:0] ADDR_MASK = ADDR_MASK64[`XLEN-1:0];

    logic [N:1]   pmp_tor_l;
    logic [N:1]   pma_tor_l;
    logic [N-1:0] pmp_alock;
    logic [N-1:0] pma_alock;

    function automatic mpu_cfg_u pmp_legal(input logic [7:0] b);
        mpu_cfg_u c;
        c = b;
        c.pmp.rsvd = 2'b00;
        c.pmp.w = c.pmp.w & c.pmp.r;
        return c;
    endfunction

    function automatic mpu_cfg_u pma_legal(input logic [7:0] b);
        mpu_cfg_u c;
        c = b;
        c.pma.rsvd0 = 2'b00;
        c.pma.rsvd1 = 1'b0;
        return c;
    endfunction

    // OFF and TOR entries hide the trailing run of ones.
    function automatic logic [`XLEN-1:0] addr_rd(input logic [`XLEN-1:0] addr,
                                                 input logic [1:0] a);
        logic [`XLEN-1:0] ones;
        ones = addr & ~(addr + 1'b1);
        return a[1] ? addr : (addr & ~ones);
    endfunction

    // an address register is frozen by its own lock or a locked TOR entry above it.
    always_comb begin
        pmp_tor_l[N] = 1'b0;
        pma_tor_l[N] = 1'b0;
        for (int i = 1; i < N; i++) begin
            pmp_tor_l[i] = pmpcfg[i].pmp.l && (pmpcfg[i].pmp.a == `A_TOR);
            pma_tor_l[i] = pmacfg[i].pma.l && (pmacfg[i].pma.a == `A_TOR);
        end
        for (int i = 0; i < N; i++) begin
            pmp_alock[i] = pmpcfg[i].pmp.l || pmp_tor_l[i+1];
            pma_alock[i] = pmacfg[i].pma.l || pma_tor_l[i+1];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < N; i++) begin
                pmpcfg[i]  <= '0;
                pmpaddr[i] <= '0;
            end
        end else if (csr_wr) begin
            for (int i = 0; i < N; i++) begin
                if ((csr_waddr == `CSR_PMPCFG0 + 12'(i / 4)) && !pmpcfg[i].pmp.l) begin
                    pmpcfg[i] <= pmp_legal(csr_wdata[(i % 4) * 8 +: 8]);
                end
                if ((csr_waddr == `CSR_PMPADDR0 + 12'(i)) && !pmp_alock[i]) begin
                    pmpaddr[i] <= csr_wdata & ADDR_MASK;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 2; i < N; i++) begin
                pmacfg[i]  <= '0;
                pmaaddr[i] <= '0;
            end
            pmacfg[0]  <= `PMA0_RST_CFG;
            pmaaddr[0] <= `PMA0_RST_ADDR;
            pmacfg[1]  <= `PMA1_RST_CFG;
            pmaaddr[1] <= `PMA1_RST_ADDR;
        end else if (csr_wr) begin
            for (int i = 0; i < N; i++) begin
                if ((csr_waddr == `CSR_PMACFG0 + 12'(i / 4)) && !pmacfg[i].pma.l) begin
                    pmacfg[i] <= pma_legal(csr_wdata[(i % 4) * 8 +: 8]);
                end
                if ((csr_waddr == `CSR_PMAADDR0 + 12'(i)) && !pma_alock[i]) begin
                    pmaaddr[i] <= csr_wdata & ADDR_MASK;
                end
            end
        end
    end

    always_comb begin
        csr_rdata = '0;
        for (int i = 0; i < N; i++) begin
            if (csr_raddr == `CSR_PMPCFG0 + 12'(i / 4)) begin
                csr_rdata[(i % 4) * 8 +: 8] = pmpcfg[i];
            end
            if (csr_raddr == `CSR_PMACFG0 + 12'(i / 4)) begin
                csr_rdata[(i % 4) * 8 +: 8] = pmacfg[i];
            end
            if (csr_raddr == `CSR_PMPADDR0 + 12'(i)) begin
                csr_rdata = addr_rd(pmpaddr[i], pmpcfg[i].pmp.a);
            end
            if (csr_raddr == `CSR_PMAADDR0 + 12'(i)) begin
                csr_rdata = addr_rd(pmaaddr[i], pmacfg[i].pma.a);
            end
        end
    end

endmodule

/* hdl/mpu_pkg.sv */
`include "mpu_defines.svh"

package mpu_pkg;

    typedef struct packed {
        logic       l;
        logic [1:0] rsvd;
        logic [1:0] a;
        logic       x;
        logic       w;
        logic       r;
    } pmp_cfg_t;

    typedef struct packed {
        logic       l;
        logic [1:0] rsvd0;
        logic [1:0] a;
        logic       rsvd1;
        logic       c;
        logic       e;
    } pma_cfg_t;

    // l and a sit at the same bits in both views.
    typedef union packed {
        pmp_cfg_t pmp;
        pma_cfg_t pma;
    } mpu_cfg_u;

    typedef enum logic [1:0] {
        acc_read  = 2'd0,
        acc_write = 2'd1,
        acc_exec  = 2'd2
    } access_t;

    typedef struct packed {
        logic [`PADDR_LEN-1:0] paddr;
        access_t               acc;
        logic                  m_mode;
    } mpu_req_t;

    typedef struct packed {
        logic     hit;
        mpu_cfg_u cfg;
    } mpu_hit_t;

    typedef struct packed {
        logic pmp_fault;
        logic pma_fault;
        logic cacheable;
    } mpu_resp_t;

endpackage

/* hdl/mpu_defines.svh */
`ifndef MPU_DEFINES_SVH
`define MPU_DEFINES_SVH

`define XLEN        32
`define PADDR_LEN   34
`define MPU_ENTRIES 16

// config registers pack four entries each.
`define CSR_PMPCFG0  12'h3A0
`define CSR_PMPCFG1  12'h3A1
`define CSR_PMPCFG2  12'h3A2
`define CSR_PMPCFG3  12'h3A3
`define CSR_PMPADDR0 12'h3B0
`define CSR_PMACFG0  12'h3C0
`define CSR_PMACFG1  12'h3C1
`define CSR_PMACFG2  12'h3C2
`define CSR_PMACFG3  12'h3C3
`define CSR_PMAADDR0 12'h3D0

`define A_OFF   2'd0
`define A_TOR   2'd1
`define A_NA4   2'd2
`define A_NAPOT 2'd3

// locked TOR regions, executable; address registers hold paddr[33:2].
`define PMA0_RST_CFG  8'h8B
`define PMA0_RST_ADDR 32'h0100_0000
`define PMA1_RST_CFG  8'h89
`define PMA1_RST_ADDR 32'h1000_0000

`endif
